//--- fetch_frontend_defines.svh
`ifndef FETCH_FRONTEND_DEFINES_SVH
`define FETCH_FRONTEND_DEFINES_SVH

// Queue geometry
`define FB_DEPTH 16 // Entries in the fetch queue
`define FB_PTR_W 5  // Occupancy count runs from 0 to FB_DEPTH

// Six-bit major opcodes of the branch and jump group
`define BR_OP_LO 6'h12
`define BR_OP_HI 6'h17

`endif

//--- fetch_frontend_pkg.sv
package fetch_frontend_pkg;

    // One 32-bit instruction word with two field layouts over the same bits
    typedef union packed {
        struct packed {
            logic [16:0] op; // Major and minor opcode of the 3R layout
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd; // Destination register
        } rfmt;
        struct packed {
            logic [5:0]  op6;  // Branch major opcode
            logic [15:0] offs; // Low part of the word offset
            logic [4:0]  rj;
            logic [4:0]  rd;
        } bfmt;
    } inst_word_u;

endpackage

//--- fetch_queue.sv
`timescale 1ns/10ps
`include "fetch_frontend_defines.svh"

module fetch_queue (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           push_valid,
    input  logic                           push_pair,
    input  logic [31:0]                    pc,
    input  logic [31:0]                    npc,
    input  logic [63:0]                    irin,
    input  logic [1:0]                     plv,
    input  logic [15:0]                    excp_arg,
    input  logic [63:0]                    pre,
    input  logic [1:0]                     pop_cnt,
    output logic                           stall_fetch,
    output logic [1:0]                     head_count,
    output fetch_frontend_pkg::inst_word_u head0_inst,
    output fetch_frontend_pkg::inst_word_u head1_inst,
    output logic [31:0]                    head0_pc,
    output logic [31:0]                    head1_pc,
    output logic [31:0]                    head0_npc,
    output logic [31:0]                    head1_npc,
    output logic [1:0]                     head0_plv,
    output logic [1:0]                     head1_plv,
    output logic [15:0]                    head0_excp_arg,
    output logic [15:0]                    head1_excp_arg,
    output logic [63:0]                    head0_pre,
    output logic [63:0]                    head1_pre
);

    localparam int DEPTH = `FB_DEPTH;
    localparam int PTR_W = `FB_PTR_W;
    localparam int IDX_W = $clog2(DEPTH);

    // Entry 0 is the oldest instruction
    fetch_frontend_pkg::inst_word_u mem_inst [DEPTH];
    logic [31:0] mem_pc   [DEPTH];
    logic [31:0] mem_npc  [DEPTH];
    logic [1:0]  mem_plv  [DEPTH];
    logic [15:0] mem_excp [DEPTH];
    logic [63:0] mem_pre  [DEPTH];

    logic [PTR_W-1:0] count;
    logic [PTR_W-1:0] keep_cnt;
    logic [PTR_W-1:0] push_cnt;
    logic [IDX_W-1:0] src_idx [DEPTH];
    logic [DEPTH-1:0] shift_en;
    logic [DEPTH-1:0] new0_en;
    logic [DEPTH-1:0] new1_en;

    assign keep_cnt = count - PTR_W'(pop_cnt); // Entries left after this cycle's issue
    assign push_cnt = push_valid ? (push_pair ? PTR_W'(2) : PTR_W'(1)) : '0;

    // Fewer than two free slots means a paired packet could not land
    assign stall_fetch = count > PTR_W'(DEPTH - 2);
    assign head_count  = (count >= PTR_W'(2)) ? 2'd2 : count[1:0];

    // Survivors move down by pop_cnt and new words land right behind them
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            src_idx[i]  = IDX_W'(i) + IDX_W'(pop_cnt);
            shift_en[i] = PTR_W'(i) < keep_cnt;
            new0_en[i]  = push_valid && (PTR_W'(i) == keep_cnt);
            new1_en[i]  = push_valid && push_pair && (PTR_W'(i) == keep_cnt + PTR_W'(1));
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (shift_en[i]) begin
                mem_inst[i] <= mem_inst[src_idx[i]];
                mem_pc[i]   <= mem_pc[src_idx[i]];
                mem_npc[i]  <= mem_npc[src_idx[i]];
                mem_plv[i]  <= mem_plv[src_idx[i]];
                mem_excp[i] <= mem_excp[src_idx[i]];
                mem_pre[i]  <= mem_pre[src_idx[i]];
            end else if (new0_en[i]) begin
                mem_inst[i] <= irin[31:0];
                mem_pc[i]   <= pc;
                mem_npc[i]  <= npc;
                mem_plv[i]  <= plv;
                mem_excp[i] <= excp_arg;
                mem_pre[i]  <= pre;
            end else if (new1_en[i]) begin
                mem_inst[i] <= irin[63:32];
                mem_pc[i]   <= pc + 32'd4; // Upper word sits one instruction later
                mem_npc[i]  <= npc;
                mem_plv[i]  <= plv;
                mem_excp[i] <= 16'd0;
                mem_pre[i]  <= pre;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= '0;
        end else begin
            count <= keep_cnt + push_cnt;
        end
    end

    assign head0_inst     = mem_inst[0];
    assign head1_inst     = mem_inst[1];
    assign head0_pc       = mem_pc[0];
    assign head1_pc       = mem_pc[1];
    assign head0_npc      = mem_npc[0];
    assign head1_npc      = mem_npc[1];
    assign head0_plv      = mem_plv[0];
    assign head1_plv      = mem_plv[1];
    assign head0_excp_arg = mem_excp[0];
    assign head1_excp_arg = mem_excp[1];
    assign head0_pre      = mem_pre[0];
    assign head1_pre      = mem_pre[1];

    // The issue side must never retire entries the queue does not hold
    a_pop_within_count: assert property (
        @(posedge clk) disable iff (rst)
        PTR_W'(pop_cnt) <= count
    ) else $error("fetch_queue popped %0d entries with %0d held", pop_cnt, count);

    // The cache side has to hold its packet while the queue is nearly full
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        stall_fetch |-> !push_valid
    ) else $error("fetch_queue push while stall_fetch is high");

endmodule

//--- issue_pair_ctrl.sv
`timescale 1ns/10ps
`include "fetch_frontend_defines.svh"

module issue_pair_ctrl (
    input  logic                           stall,
    input  logic [1:0]                     head_count,
    input  fetch_frontend_pkg::inst_word_u head0_inst,
    input  fetch_frontend_pkg::inst_word_u head1_inst,
    input  logic [15:0]                    head0_excp_arg,
    output logic [1:0]                     pop_cnt,
    output logic                           issue0_valid,
    output logic                           issue1_valid
);

    logic older_branch;
    logic older_excp;
    logic raw_hazard;
    logic pair_ok;

    // Branch test reads the word through the branch layout
    assign older_branch = (head0_inst.bfmt.op6 >= `BR_OP_LO) &&
                          (head0_inst.bfmt.op6 <= `BR_OP_HI);

    assign older_excp = head0_excp_arg != 16'd0;

    // r0 is hardwired to zero so writing it never creates a dependency
    assign raw_hazard = (head0_inst.rfmt.rd != 5'd0) &&
                        ((head0_inst.rfmt.rd == head1_inst.rfmt.rj) ||
                         (head0_inst.rfmt.rd == head1_inst.rfmt.rk));

    assign pair_ok = (head_count == 2'd2) && !older_branch && !older_excp && !raw_hazard;

    assign issue0_valid = !stall && (head_count != 2'd0);
    assign issue1_valid = issue0_valid && pair_ok; // Younger slot only rides along the older

    assign pop_cnt = {1'b0, issue0_valid} + {1'b0, issue1_valid};

endmodule

//--- fetch_frontend.sv
`timescale 1ns/10ps

module fetch_frontend (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic                           stall,
    input  logic                           icache_valid,
    input  logic                           pair,
    input  logic [31:0]                    pc,
    input  logic [31:0]                    npc,
    input  logic [63:0]                    irin,
    input  logic [1:0]                     plv,
    input  logic [15:0]                    excp_arg,
    input  logic [63:0]                    pre,
    output logic                           stall_fetch,
    output logic                           issue0_valid,
    output fetch_frontend_pkg::inst_word_u issue0_inst,
    output logic [31:0]                    issue0_pc,
    output logic [31:0]                    issue0_npc,
    output logic [1:0]                     issue0_plv,
    output logic [15:0]                    issue0_excp_arg,
    output logic [63:0]                    issue0_pre,
    output logic                           issue1_valid,
    output fetch_frontend_pkg::inst_word_u issue1_inst,
    output logic [31:0]                    issue1_pc,
    output logic [31:0]                    issue1_npc,
    output logic [1:0]                     issue1_plv,
    output logic [15:0]                    issue1_excp_arg,
    output logic [63:0]                    issue1_pre
);

    logic       push_valid;
    logic [1:0] head_count;
    logic [1:0] pop_cnt;

    assign push_valid = icache_valid && !stall_fetch; // Cache retries a refused packet

    // Head entries feed the issue ports directly and the control only picks the count
    fetch_queue i_fetch_queue (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .push_valid     (push_valid),
        .push_pair      (pair),
        .pc             (pc),
        .npc            (npc),
        .irin           (irin),
        .plv            (plv),
        .excp_arg       (excp_arg),
        .pre            (pre),
        .pop_cnt        (pop_cnt),
        .stall_fetch    (stall_fetch),
        .head_count     (head_count),
        .head0_inst     (issue0_inst),
        .head1_inst     (issue1_inst),
        .head0_pc       (issue0_pc),
        .head1_pc       (issue1_pc),
        .head0_npc      (issue0_npc),
        .head1_npc      (issue1_npc),
        .head0_plv      (issue0_plv),
        .head1_plv      (issue1_plv),
        .head0_excp_arg (issue0_excp_arg),
        .head1_excp_arg (issue1_excp_arg),
        .head0_pre      (issue0_pre),
        .head1_pre      (issue1_pre)
    );

    issue_pair_ctrl i_issue_pair_ctrl (
        .stall          (stall),
        .head_count     (head_count),
        .head0_inst     (issue0_inst),
        .head1_inst     (issue1_inst),
        .head0_excp_arg (issue0_excp_arg),
        .pop_cnt        (pop_cnt),
        .issue0_valid   (issue0_valid),
        .issue1_valid   (issue1_valid)
    );

endmodule

//--- tb_fetch_frontend.sv
`timescale 1ns/10ps
`include "fetch_frontend_defines.svh"

module tb_fetch_frontend;

    localparam int FIELDS  = 9;  // Hex words per record in the data file
    localparam int MAX_REC = 64;

    logic                           clk;
    logic                           rst;
    logic                           flush;
    logic                           stall;
    logic                           icache_valid;
    logic                           pair;
    logic [31:0]                    pc;
    logic [31:0]                    npc;
    logic [63:0]                    irin;
    logic [1:0]                     plv;
    logic [15:0]                    excp_arg;
    logic [63:0]                    pre;
    logic                           stall_fetch;
    logic                           issue0_valid;
    fetch_frontend_pkg::inst_word_u issue0_inst;
    logic [31:0]                    issue0_pc;
    logic [31:0]                    issue0_npc;
    logic [1:0]                     issue0_plv;
    logic [15:0]                    issue0_excp_arg;
    logic [63:0]                    issue0_pre;
    logic                           issue1_valid;
    fetch_frontend_pkg::inst_word_u issue1_inst;
    logic [31:0]                    issue1_pc;
    logic [31:0]                    issue1_npc;
    logic [1:0]                     issue1_plv;
    logic [15:0]                    issue1_excp_arg;
    logic [63:0]                    issue1_pre;

    // Expected instructions in program order with the oldest at index 0
    fetch_frontend_pkg::inst_word_u exp_inst [$];
    logic [31:0] exp_pc   [$];
    logic [31:0] exp_npc  [$];
    logic [1:0]  exp_plv  [$];
    logic [15:0] exp_excp [$];
    logic [63:0] exp_pre  [$];

    logic [63:0] rec_mem [MAX_REC*FIELDS];
    int          nrec;
    int          rec;
    int          stall_left;
    int          cycle;
    int          limit;
    logic [31:0] lcg_state;
    logic        saw_full;

    fetch_frontend i_fetch_frontend (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s expected %0b got %0b", $time, what, exp, got));
    endtask

    task automatic check_inst(input fetch_frontend_pkg::inst_word_u got,
                              input fetch_frontend_pkg::inst_word_u exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got));
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got));
    endtask

    task automatic check_plv(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s expected %0d got %0d", $time, what, exp, got));
    endtask

    task automatic check_excp(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got));
    endtask

    task automatic check_pre(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [63:0] field(input int r, input int f);
        logic [9:0] idx;
        idx = 10'(r * FIELDS + f);
        return rec_mem[idx];
    endfunction

    // Older word may pair unless it branches, carries an exception or feeds the younger one
    function automatic logic pair_allowed(input logic [31:0] older, input logic [15:0] older_excp,
                                          input logic [31:0] younger);
        logic is_branch;
        logic hazard;
        is_branch = (older[31:26] >= `BR_OP_LO) && (older[31:26] <= `BR_OP_HI);
        hazard    = (older[4:0] != 5'd0) &&
                    ((older[4:0] == younger[9:5]) || (older[4:0] == younger[14:10]));
        return !is_branch && (older_excp == 16'd0) && !hazard;
    endfunction

    task automatic push_expected(input logic [31:0] word, input logic [31:0] addr,
                                 input logic [15:0] excp);
        exp_inst.push_back(word);
        exp_pc.push_back(addr);
        exp_npc.push_back(npc);
        exp_plv.push_back(plv);
        exp_excp.push_back(excp);
        exp_pre.push_back(pre);
    endtask

    task automatic compare_slot(input int slot, input fetch_frontend_pkg::inst_word_u inst,
                                input logic [31:0] pc_v, input logic [31:0] npc_v,
                                input logic [1:0] plv_v, input logic [15:0] excp_v,
                                input logic [63:0] pre_v);
        string tag;
        tag = $sformatf("slot %0d", slot);
        check_inst(inst, exp_inst[0], {tag, " inst"});
        check_word(pc_v, exp_pc[0], {tag, " pc"});
        check_word(npc_v, exp_npc[0], {tag, " npc"});
        check_plv(plv_v, exp_plv[0], {tag, " plv"});
        check_excp(excp_v, exp_excp[0], {tag, " excp_arg"});
        check_pre(pre_v, exp_pre[0], {tag, " pre"});
        void'(exp_inst.pop_front());
        void'(exp_pc.pop_front());
        void'(exp_npc.pop_front());
        void'(exp_plv.pop_front());
        void'(exp_excp.pop_front());
        void'(exp_pre.pop_front());
    endtask

    task automatic drive_cycle();
        logic [63:0] kind;
        icache_valid = 1'b0;
        flush        = 1'b0;
        if (rec < nrec) begin
            kind = field(rec, 0);
            if (kind == 64'd1) begin // Packet stays on the bus until it is taken
                pc           = 32'(field(rec, 1));
                npc          = 32'(field(rec, 2));
                irin         = {32'(field(rec, 4)), 32'(field(rec, 3))};
                pair         = 1'(field(rec, 5));
                plv          = 2'(field(rec, 6));
                excp_arg     = 16'(field(rec, 7));
                pre          = field(rec, 8);
                icache_valid = 1'b1;
            end else if (kind == 64'd2) begin
                flush = 1'b1;
                rec++;
            end else begin
                stall_left = int'(field(rec, 1)); // Runs alongside the following packets
                rec++;
            end
        end
        lcg_state = lcg_next(lcg_state);
        stall     = (stall_left != 0) || (lcg_state[20:18] == 3'd0);
        if (stall_left != 0)
            stall_left--;
    endtask

    task automatic check_cycle();
        int   held;
        logic exp_v0;
        logic exp_v1;
        held   = exp_pc.size();
        exp_v0 = !stall && (held != 0);
        exp_v1 = 1'b0;
        if (exp_v0 && held >= 2)
            exp_v1 = pair_allowed(exp_inst[0], exp_excp[0], exp_inst[1]);
        check_flag(stall_fetch, (`FB_DEPTH - held) < 2, "stall_fetch");
        check_flag(issue0_valid, exp_v0, "issue0_valid");
        check_flag(issue1_valid, exp_v1, "issue1_valid");
        if (stall_fetch)
            saw_full = 1'b1;
        if (issue0_valid)
            compare_slot(0, issue0_inst, issue0_pc, issue0_npc, issue0_plv,
                         issue0_excp_arg, issue0_pre);
        if (issue1_valid)
            compare_slot(1, issue1_inst, issue1_pc, issue1_npc, issue1_plv,
                         issue1_excp_arg, issue1_pre);
        if (flush) begin // This cycle's issues still count before the queue empties
            exp_inst.delete();
            exp_pc.delete();
            exp_npc.delete();
            exp_plv.delete();
            exp_excp.delete();
            exp_pre.delete();
        end else if (icache_valid && !stall_fetch) begin
            push_expected(irin[31:0], pc, excp_arg);
            if (pair)
                push_expected(irin[63:32], pc + 32'd4, 16'd0);
            rec++;
        end
    endtask

    initial begin
        rst          = 1'b1;
        flush        = 1'b0;
        stall        = 1'b0;
        icache_valid = 1'b0;
        pair         = 1'b0;
        pc           = '0;
        npc          = '0;
        irin         = '0;
        plv          = '0;
        excp_arg     = '0;
        pre          = '0;
        lcg_state    = 32'h3c8b_2f38;
        saw_full     = 1'b0;
        stall_left   = 0;
        cycle        = 0;
        rec          = 0;
        nrec         = 0;
        $readmemh("fetch_frontend_tests.txt", rec_mem);
        while (nrec < MAX_REC && field(nrec, 0) inside {64'd1, 64'd2, 64'd3})
            nrec++;
        if (nrec == 0)
            abort_run("The data file holds no test records");
        limit = 40 * nrec + 100;

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_flag(issue0_valid, 1'b0, "issue0_valid after reset");
        check_flag(issue1_valid, 1'b0, "issue1_valid after reset");
        check_flag(stall_fetch, 1'b0, "stall_fetch after reset");

        while (rec < nrec || exp_pc.size() != 0) begin
            @(posedge clk);
            #2;
            drive_cycle();
            @(negedge clk); // Issue ports have settled from the head and the stall input
            check_cycle();
            cycle++;
            if (cycle > limit)
                abort_run($sformatf("The run timed out after %0d cycles with %0d instructions left",
                                    cycle, exp_pc.size()));
        end
        if (!saw_full) begin
            abort_run("stall_fetch never rose during the back-pressure burst");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- fetch_frontend_tests.txt
// Columns: kind pc npc word0 word1 pair plv excp_arg pre
// Kind 1 is a cache packet, 2 a flush, 3 a backend stall of pc cycles, 0 ends the list
1 1c000000 1c000008 00100823 00101486 1 0 0000 a0a0000000000001
1 1c000008 1c000010 00100823 00100867 1 0 0000 a0a0000000000002
1 1c000010 1c000018 48001085 00101486 1 0 0000 a0a0000000000003
1 1c000018 1c00001c 00100400 00000000 0 3 0000 a0a0000000000004
1 1c00001c 1c000024 00100404 00101045 1 3 0000 a0a0000000000005
1 1c000024 1c00002c 00101486 00100823 1 0 0021 a0a0000000000006
1 1c00002c 1c000034 60000443 00100001 1 0 0000 a0a0000000000007
1 1c000034 1c00003c 5c000c41 00100823 1 1 0000 a0a0000000000008
3 00000028 00000000 00000000 00000000 0 0 0000 0000000000000000
1 1c000100 1c000108 00100823 00101486 1 0 0000 b0b0000000000001
1 1c000108 1c000110 00100400 00100001 1 0 0000 b0b0000000000002
1 1c000110 1c000118 00100823 00100867 1 1 0000 b0b0000000000003
1 1c000118 1c000120 4c000862 00101486 1 1 0000 b0b0000000000004
1 1c000120 1c000128 00101486 00100823 1 0 0000 b0b0000000000005
1 1c000128 1c000130 00100404 00101045 1 2 0000 b0b0000000000006
1 1c000130 1c000138 60000443 00100001 1 0 0000 b0b0000000000007
1 1c000138 1c000140 00100823 00101486 1 0 0000 b0b0000000000008
1 1c000140 1c000148 44000c41 00100867 1 3 0000 b0b0000000000009
1 1c000148 1c000150 00101486 00100823 1 0 0000 b0b000000000000a
2 00000000 00000000 00000000 00000000 0 0 0000 0000000000000000
1 1c000800 1c000808 00100823 00101486 1 0 0008 c0c0000000000001
3 00000006 00000000 00000000 00000000 0 0 0000 0000000000000000
1 1c000808 1c000810 44000c41 00100867 1 2 0000 c0c0000000000002
1 1c000810 1c000814 5c000c41 00000000 0 2 0000 c0c0000000000003
1 1c000814 1c00081c 00100404 00101045 1 0 0000 c0c0000000000004
2 00000000 00000000 00000000 00000000 0 0 0000 0000000000000000
1 1c000900 1c000908 00100001 00100823 1 0 0000 d0d0000000000001
1 1c000908 1c000910 00101486 60000443 1 1 0000 d0d0000000000002
0 00000000 00000000 00000000 00000000 0 0 0000 0000000000000000

//--- fetch_frontend.f
+incdir+.
fetch_frontend_pkg.sv
fetch_queue.sv
issue_pair_ctrl.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_fetch_frontend -f fetch_frontend.f \
    -o sim_fetch_frontend \
    && ./obj_dir/sim_fetch_frontend | tee /dev/stderr | grep "^Simulation passed$" > /dev/null \
    && echo "Run result: PASS" \
    || { echo "Run result: FAIL"; exit 1; }
